// File: hdl/exu_cfg.svh
/* widths of the execute stage datapath, register index, commit tag and ALU op code */

`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// integer datapath width
`define EXU_XLEN 32

// architectural register index
`define EXU_REG_ADDR_W 5

// reorder tag carried with every result
`define EXU_COMMIT_ID_W 3

// ALU operation code
`define EXU_ALU_OP_W 4

`endif

// File: hdl/exu_types_pkg.sv
/* vector types for operands, register indices, commit tags and addresses */

`include "exu_cfg.svh"

package exu_types_pkg;

    // operand or result word
    typedef logic [`EXU_XLEN-1:0] xdata_t;

    // destination register index
    typedef logic [`EXU_REG_ADDR_W-1:0] reg_addr_t;

    // reorder tag
    typedef logic [`EXU_COMMIT_ID_W-1:0] commit_id_t;

    // instruction address, same width as the datapath
    typedef logic [`EXU_XLEN-1:0] inst_addr_t;

endpackage

// File: hdl/exu_ops_pkg.sv
/* operation encodings for the ALU, multiplier and branch unit */

`include "exu_cfg.svh"

package exu_ops_pkg;

    typedef enum logic [`EXU_ALU_OP_W-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        MUL_OP_MUL    = 2'd0,
        MUL_OP_MULH   = 2'd1,
        MUL_OP_MULHSU = 2'd2,
        MUL_OP_MULHU  = 2'd3
    } mul_op_e;

    typedef enum logic [2:0] {
        BRU_JAL  = 3'd0,
        BRU_JALR = 3'd1,
        BRU_BEQ  = 3'd2,
        BRU_BNE  = 3'd3,
        BRU_BLT  = 3'd4,
        BRU_BGE  = 3'd5,
        BRU_BLTU = 3'd6,
        BRU_BGEU = 3'd7
    } bru_op_e;

endpackage

// File: hdl/exu_alu.sv
/* single-cycle integer ALU lane with a write-back register held under back-pressure */

`timescale 1ns/1ps

module exu_alu
    import exu_types_pkg::*;
    import exu_ops_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       int_assert_i,
    input  logic       req_alu_i,
    input  xdata_t     alu_op1_i,
    input  xdata_t     alu_op2_i,
    input  alu_op_e    alu_op_i,
    input  reg_addr_t  rd_i,
    input  commit_id_t commit_id_i,
    input  logic       wb_ready_i,
    output logic       alu_stall_o,
    output xdata_t     reg_wdata_o,
    output reg_addr_t  reg_waddr_o,
    output commit_id_t commit_id_o,
    output logic       reg_we_o
);

    xdata_t result;
    logic   accept;

    // held result not yet taken by write-back
    assign alu_stall_o = reg_we_o & ~wb_ready_i;
    assign accept      = req_alu_i & ~alu_stall_o;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result = alu_op1_i + alu_op2_i;
            ALU_SUB:  result = alu_op1_i - alu_op2_i;
            ALU_SLL:  result = alu_op1_i << alu_op2_i[4:0];
            ALU_SLT:  result = xdata_t'($signed(alu_op1_i) < $signed(alu_op2_i));
            ALU_SLTU: result = xdata_t'(alu_op1_i < alu_op2_i);
            ALU_XOR:  result = alu_op1_i ^ alu_op2_i;
            ALU_SRL:  result = alu_op1_i >> alu_op2_i[4:0];
            ALU_SRA:  result = xdata_t'($signed(alu_op1_i) >>> alu_op2_i[4:0]);
            ALU_OR:   result = alu_op1_i | alu_op2_i;
            ALU_AND:  result = alu_op1_i & alu_op2_i;
            default:  result = '0;
        endcase
    end

    // valid bit, dropped on interrupt or when consumed without a new request
    always_ff @(posedge clk) begin
        if (reset_i || int_assert_i) begin
            reg_we_o <= 1'b0;
        end else if (accept) begin
            reg_we_o <= 1'b1;
        end else if (wb_ready_i) begin
            reg_we_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reg_wdata_o <= result;
            reg_waddr_o <= rd_i;
            commit_id_o <= commit_id_i;
        end
    end

endmodule

// File: hdl/exu_mul.sv
/* two-stage pipelined multiplier lane for mul, mulh, mulhsu and mulhu */

`timescale 1ns/1ps

`include "exu_cfg.svh"

module exu_mul
    import exu_types_pkg::*;
    import exu_ops_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       int_assert_i,
    input  logic       req_mul_i,
    input  xdata_t     mul_op1_i,
    input  xdata_t     mul_op2_i,
    input  mul_op_e    mul_op_i,
    input  reg_addr_t  rd_i,
    input  commit_id_t commit_id_i,
    input  logic       wb_ready_i,
    output logic       mul_stall_o,
    output xdata_t     reg_wdata_o,
    output reg_addr_t  reg_waddr_o,
    output commit_id_t commit_id_o,
    output logic       reg_we_o
);

    logic signed [`EXU_XLEN:0]     op1_ext;
    logic signed [`EXU_XLEN:0]     op2_ext;
    logic signed [2*`EXU_XLEN+1:0] prod_full;

    // stage one holds the full product
    logic                     s1_valid;
    logic [2*`EXU_XLEN-1:0]   s1_prod;
    mul_op_e                  s1_op;
    reg_addr_t                s1_rd;
    commit_id_t               s1_cid;

    logic s1_ready;
    logic s2_ready;
    logic accept;

    // stage two is the write-back register itself
    assign s2_ready    = ~reg_we_o | wb_ready_i;
    assign s1_ready    = ~s1_valid | s2_ready;
    assign mul_stall_o = ~s1_ready;
    assign accept      = req_mul_i & s1_ready;

    // op1 signed for mulh and mulhsu, op2 signed only for mulh
    always_comb begin
        op1_ext   = {(mul_op_i == MUL_OP_MULH || mul_op_i == MUL_OP_MULHSU) & mul_op1_i[31],
                     mul_op1_i};
        op2_ext   = {(mul_op_i == MUL_OP_MULH) & mul_op2_i[31], mul_op2_i};
        prod_full = (2*`EXU_XLEN+2)'(op1_ext) * (2*`EXU_XLEN+2)'(op2_ext);
    end

    always_ff @(posedge clk) begin
        if (reset_i || int_assert_i) begin
            s1_valid <= 1'b0;
            reg_we_o <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid <= req_mul_i;
            end
            if (s2_ready) begin
                reg_we_o <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_prod <= prod_full[2*`EXU_XLEN-1:0];
            s1_op   <= mul_op_i;
            s1_rd   <= rd_i;
            s1_cid  <= commit_id_i;
        end
        if (s1_valid && s2_ready) begin
            // mul keeps the low word, the others the high word
            reg_wdata_o <= (s1_op == MUL_OP_MUL) ? s1_prod[`EXU_XLEN-1:0]
                                                 : s1_prod[2*`EXU_XLEN-1:`EXU_XLEN];
            reg_waddr_o <= s1_rd;
            commit_id_o <= s1_cid;
        end
    end

endmodule

// File: hdl/exu_bru.sv
/* combinational branch and jump resolution with target alignment check */

`timescale 1ns/1ps

module exu_bru
    import exu_types_pkg::*;
    import exu_ops_pkg::*;
(
    input  logic       req_bjp_i,
    input  xdata_t     bjp_op1_i,
    input  xdata_t     bjp_op2_i,
    input  inst_addr_t bjp_jump_op1_i,
    input  inst_addr_t bjp_jump_op2_i,
    input  bru_op_e    bjp_op_i,
    output logic       jump_flag_o,
    output inst_addr_t jump_addr_o,
    output logic       misaligned_fetch_o
);

    logic       op_eq;
    logic       op_lt;
    logic       op_ltu;
    logic       cond;
    inst_addr_t target;

    assign op_eq  = (bjp_op1_i == bjp_op2_i);
    assign op_lt  = ($signed(bjp_op1_i) < $signed(bjp_op2_i));
    assign op_ltu = (bjp_op1_i < bjp_op2_i);

    always_comb begin
        case (bjp_op_i)
            BRU_JAL:  cond = 1'b1;
            BRU_JALR: cond = 1'b1;
            BRU_BEQ:  cond = op_eq;
            BRU_BNE:  cond = ~op_eq;
            BRU_BLT:  cond = op_lt;
            BRU_BGE:  cond = ~op_lt;
            BRU_BLTU: cond = op_ltu;
            BRU_BGEU: cond = ~op_ltu;
            default:  cond = 1'b0;
        endcase
    end

    // jalr drops bit 0 of the sum
    always_comb begin
        target = bjp_jump_op1_i + bjp_jump_op2_i;
        if (bjp_op_i == BRU_JALR) begin
            target[0] = 1'b0;
        end
    end

    // without compressed instructions a taken target must be word aligned
    assign misaligned_fetch_o = req_bjp_i & cond & target[1];
    assign jump_flag_o        = req_bjp_i & cond & ~target[1];
    assign jump_addr_o        = target;

endmodule

// File: hdl/exu.sv
/* execute stage top level with ALU lane, multiplier lane and branch unit */

`timescale 1ns/1ps

module exu
    import exu_types_pkg::*;
    import exu_ops_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       int_assert_i,
    input  logic       int_jump_i,
    input  inst_addr_t int_addr_i,

    // ALU lane request
    input  logic       req_alu_i,
    input  xdata_t     alu_op1_i,
    input  xdata_t     alu_op2_i,
    input  alu_op_e    alu_op_i,
    input  reg_addr_t  alu_rd_i,
    input  commit_id_t alu_commit_id_i,
    input  logic       alu_wb_ready_i,

    // multiplier lane request
    input  logic       req_mul_i,
    input  xdata_t     mul_op1_i,
    input  xdata_t     mul_op2_i,
    input  mul_op_e    mul_op_i,
    input  reg_addr_t  mul_rd_i,
    input  commit_id_t mul_commit_id_i,
    input  logic       mul_wb_ready_i,

    // branch request
    input  logic       req_bjp_i,
    input  xdata_t     bjp_op1_i,
    input  xdata_t     bjp_op2_i,
    input  inst_addr_t bjp_jump_op1_i,
    input  inst_addr_t bjp_jump_op2_i,
    input  bru_op_e    bjp_op_i,

    // write-back records
    output xdata_t     alu_reg_wdata_o,
    output logic       alu_reg_we_o,
    output reg_addr_t  alu_reg_waddr_o,
    output commit_id_t alu_commit_id_o,
    output xdata_t     mul_reg_wdata_o,
    output logic       mul_reg_we_o,
    output reg_addr_t  mul_reg_waddr_o,
    output commit_id_t mul_commit_id_o,

    // control to the front end
    output logic       stall_flag_o,
    output logic       jump_flag_o,
    output inst_addr_t jump_addr_o,
    output logic       misaligned_fetch_o
);

    logic       alu_stall;
    logic       mul_stall;
    logic       bru_jump_flag;
    inst_addr_t bru_jump_addr;

    exu_alu u_alu (
        .clk          (clk),
        .reset_i      (reset_i),
        .int_assert_i (int_assert_i),
        .req_alu_i    (req_alu_i),
        .alu_op1_i    (alu_op1_i),
        .alu_op2_i    (alu_op2_i),
        .alu_op_i     (alu_op_i),
        .rd_i         (alu_rd_i),
        .commit_id_i  (alu_commit_id_i),
        .wb_ready_i   (alu_wb_ready_i),
        .alu_stall_o  (alu_stall),
        .reg_wdata_o  (alu_reg_wdata_o),
        .reg_waddr_o  (alu_reg_waddr_o),
        .commit_id_o  (alu_commit_id_o),
        .reg_we_o     (alu_reg_we_o)
    );

    exu_mul u_mul (
        .clk          (clk),
        .reset_i      (reset_i),
        .int_assert_i (int_assert_i),
        .req_mul_i    (req_mul_i),
        .mul_op1_i    (mul_op1_i),
        .mul_op2_i    (mul_op2_i),
        .mul_op_i     (mul_op_i),
        .rd_i         (mul_rd_i),
        .commit_id_i  (mul_commit_id_i),
        .wb_ready_i   (mul_wb_ready_i),
        .mul_stall_o  (mul_stall),
        .reg_wdata_o  (mul_reg_wdata_o),
        .reg_waddr_o  (mul_reg_waddr_o),
        .commit_id_o  (mul_commit_id_o),
        .reg_we_o     (mul_reg_we_o)
    );

    exu_bru u_bru (
        .req_bjp_i          (req_bjp_i),
        .bjp_op1_i          (bjp_op1_i),
        .bjp_op2_i          (bjp_op2_i),
        .bjp_jump_op1_i     (bjp_jump_op1_i),
        .bjp_jump_op2_i     (bjp_jump_op2_i),
        .bjp_op_i           (bjp_op_i),
        .jump_flag_o        (bru_jump_flag),
        .jump_addr_o        (bru_jump_addr),
        .misaligned_fetch_o (misaligned_fetch_o)
    );

    // either lane blocks dispatch
    assign stall_flag_o = alu_stall | mul_stall;

    // interrupt jump wins over the branch target
    assign jump_flag_o = bru_jump_flag | int_jump_i;
    assign jump_addr_o = int_jump_i ? int_addr_i : bru_jump_addr;

endmodule

// File: tests/exu_tb.sv
/* data-driven testbench for the execute stage, with result queues, checker and watchdog */

`timescale 1ns/1ps

module exu_tb
    import exu_ops_pkg::*;
;
    logic clk, reset_i, int_assert_i, int_jump_i;
    logic [31:0] int_addr_i;
    logic req_alu_i, alu_wb_ready_i, req_mul_i, mul_wb_ready_i, req_bjp_i;
    logic [31:0] alu_op1_i, alu_op2_i, mul_op1_i, mul_op2_i;
    logic [31:0] bjp_op1_i, bjp_op2_i, bjp_jump_op1_i, bjp_jump_op2_i;
    alu_op_e alu_op_i;
    mul_op_e mul_op_i;
    bru_op_e bjp_op_i;
    logic [4:0] alu_rd_i, mul_rd_i, alu_reg_waddr_o, mul_reg_waddr_o;
    logic [2:0] alu_commit_id_i, mul_commit_id_i, alu_commit_id_o, mul_commit_id_o;
    logic [31:0] alu_reg_wdata_o, mul_reg_wdata_o, jump_addr_o;
    logic alu_reg_we_o, mul_reg_we_o, stall_flag_o, jump_flag_o, misaligned_fetch_o;

    // vector storage and expected write-back records {cid, rd, data}
    string v_unit[64];
    logic [31:0] v_op[64], v_a[64], v_b[64], v_ja[64], v_jb[64];
    logic [31:0] v_rd[64], v_cid[64], v_exp[64], v_flg[64];
    logic [39:0] alu_q[$];
    logic [39:0] mul_q[$];
    logic [39:0] exp_rec;
    integer n_vec = 0;
    integer val_errors = 0;
    integer other_errors = 0;
    integer stall_seen = 0;
    integer seed = 32'ha248;
    logic drain = 1'b0;
    logic hold = 1'b0;

    exu dut (.*);

    always #5 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            val_errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    // pops the lane queue and compares one consumed record
    task automatic match_writeback(input string lane, inout logic [39:0] q[$],
                                   input logic [31:0] data, input logic [4:0] rd,
                                   input logic [2:0] cid);
        if (q.size() == 0) begin
            other_errors++;
            $display("%s lane delivered a result that was never requested", lane);
        end else begin
            exp_rec = q.pop_front();
            compare_value({lane, "_reg_wdata_o"}, data, exp_rec[31:0]);
            compare_value({lane, "_reg_waddr_o"}, {27'd0, rd}, {27'd0, exp_rec[36:32]});
            compare_value({lane, "_commit_id_o"}, {29'd0, cid}, {29'd0, exp_rec[39:37]});
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset_i) begin
            if (stall_flag_o) stall_seen++;
            if (alu_reg_we_o && alu_wb_ready_i)
                match_writeback("alu", alu_q, alu_reg_wdata_o, alu_reg_waddr_o,
                                alu_commit_id_o);
            if (mul_reg_we_o && mul_wb_ready_i)
                match_writeback("mul", mul_q, mul_reg_wdata_o, mul_reg_waddr_o,
                                mul_commit_id_o);
        end
    end

    // one clock step, forcing the idle lane ready so stall_flag_o reflects only the busy lane
    task automatic next_cycle(input logic force_alu, input logic force_mul);
        logic [31:0] r;
        @(posedge clk);
        r = $random(seed);
        alu_wb_ready_i <= !hold && (drain || force_alu || r[0]);
        mul_wb_ready_i <= !hold && (drain || force_mul || r[1]);
        req_alu_i <= 1'b0;
        req_mul_i <= 1'b0;
        req_bjp_i <= 1'b0;
        int_jump_i <= 1'b0;
        int_assert_i <= 1'b0;
    endtask

    task automatic issue_lane(input integer i);
        logic done;
        done = 1'b0;
        while (!done) begin
            next_cycle(v_unit[i] == "mul", v_unit[i] == "alu");
            if (v_unit[i] == "alu") begin
                req_alu_i <= 1'b1;
                alu_op_i <= alu_op_e'(v_op[i][3:0]);
                alu_op1_i <= v_a[i];
                alu_op2_i <= v_b[i];
                alu_rd_i <= v_rd[i][4:0];
                alu_commit_id_i <= v_cid[i][2:0];
            end else begin
                req_mul_i <= 1'b1;
                mul_op_i <= mul_op_e'(v_op[i][1:0]);
                mul_op1_i <= v_a[i];
                mul_op2_i <= v_b[i];
                mul_rd_i <= v_rd[i][4:0];
                mul_commit_id_i <= v_cid[i][2:0];
            end
            @(negedge clk);
            if (!stall_flag_o) begin
                done = 1'b1;
                if (v_unit[i] == "alu") alu_q.push_back({v_cid[i][2:0], v_rd[i][4:0], v_exp[i]});
                else mul_q.push_back({v_cid[i][2:0], v_rd[i][4:0], v_exp[i]});
            end
        end
    endtask

    task automatic drive_branch(input integer i);
        next_cycle(1'b0, 1'b0);
        req_bjp_i <= 1'b1;
        bjp_op_i <= bru_op_e'(v_op[i][2:0]);
        bjp_op1_i <= v_a[i];
        bjp_op2_i <= v_b[i];
        bjp_jump_op1_i <= v_ja[i];
        bjp_jump_op2_i <= v_jb[i];
        if (v_unit[i] == "int") begin
            int_jump_i <= 1'b1;
            int_addr_i <= v_exp[i];
        end
        @(negedge clk);
        compare_value("jump_flag_o", {31'd0, jump_flag_o}, {31'd0, v_flg[i][0]});
        compare_value("misaligned_fetch_o", {31'd0, misaligned_fetch_o}, {31'd0, v_flg[i][1]});
        if (v_flg[i] != 0) compare_value("jump_addr_o", jump_addr_o, v_exp[i]);
    endtask

    task automatic load_vectors();
        integer fd;
        string line;
        fd = $fopen("tests/exu_input.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open the vector file");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 2 && line[0] != "#") begin
                    if ($sscanf(line, "%s %h %h %h %h %h %h %h %h %h", v_unit[n_vec], v_op[n_vec],
                                v_a[n_vec], v_b[n_vec], v_ja[n_vec], v_jb[n_vec], v_rd[n_vec],
                                v_cid[n_vec], v_exp[n_vec], v_flg[n_vec]) == 10)
                        n_vec++;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset_i = 1'b1;
        int_assert_i = 1'b0;
        int_jump_i = 1'b0;
        int_addr_i = '0;
        req_alu_i = 1'b0;
        alu_wb_ready_i = 1'b0;
        req_mul_i = 1'b0;
        mul_wb_ready_i = 1'b0;
        req_bjp_i = 1'b0;
        alu_op1_i = '0;
        alu_op2_i = '0;
        mul_op1_i = '0;
        mul_op2_i = '0;
        bjp_op1_i = '0;
        bjp_op2_i = '0;
        bjp_jump_op1_i = '0;
        bjp_jump_op2_i = '0;
        alu_op_i = ALU_ADD;
        mul_op_i = MUL_OP_MUL;
        bjp_op_i = BRU_BEQ;
        alu_rd_i = '0;
        mul_rd_i = '0;
        alu_commit_id_i = '0;
        mul_commit_id_i = '0;
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        if (alu_reg_we_o || mul_reg_we_o || stall_flag_o || jump_flag_o || misaligned_fetch_o) begin
            other_errors++;
            $display("outputs not idle after reset");
        end
        load_vectors();
        for (integer i = 0; i < n_vec; i++) begin
            if (v_unit[i] == "alu" || v_unit[i] == "mul") issue_lane(i);
            else drive_branch(i);
        end
        drain = 1'b1;
        while (alu_q.size() != 0 || mul_q.size() != 0) next_cycle(1'b0, 1'b0);
        // pending results must vanish on the interrupt
        hold = 1'b1;
        next_cycle(1'b0, 1'b0);
        req_alu_i <= 1'b1;
        req_mul_i <= 1'b1;
        next_cycle(1'b0, 1'b0);
        int_assert_i <= 1'b1;
        // the ALU result is held while write-back is blocked
        @(negedge clk);
        if (!alu_reg_we_o) begin
            other_errors++;
            $display("no ALU result was pending before the interrupt");
        end
        repeat (3) begin
            next_cycle(1'b0, 1'b0);
            @(negedge clk);
            if (alu_reg_we_o || mul_reg_we_o) begin
                other_errors++;
                $display("a result survived the interrupt");
            end
        end
        if (stall_seen == 0) begin
            other_errors++;
            $display("stall_flag_o was never seen high");
        end
        $display("errors: %0d wrong values, %0d other failures", val_errors, other_errors);
        if (val_errors == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // 50 cycles per vector
    initial begin
        wait (n_vec > 0);
        repeat (n_vec * 50) @(posedge clk);
        $display("timeout: the run did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+hdl
hdl/exu_types_pkg.sv
hdl/exu_ops_pkg.sv
hdl/exu_alu.sv
hdl/exu_mul.sv
hdl/exu_bru.sv
hdl/exu.sv
tests/exu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= exu_tb
FLIST     ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0

SRCS := $(shell grep -v '^+' $(FLIST)) hdl/exu_cfg.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q 'SIMULATION PASSED'

clean:
	rm -rf $(BUILD_DIR)

// File: tests/exu_input.txt
# unit op op1 op2 jump_op1 jump_op2 rd commit_id expected flags (all hex)
# alu/mul: expected is the result; bru/int: expected is jump_addr_o, flags = {misaligned, jump}
alu 0 7fffffff 00000001 0 0 01 0 80000000 0
alu 1 00000005 00000007 0 0 02 1 fffffffe 0
alu 2 00000003 00000004 0 0 03 2 00000030 0
alu 3 ffffffff 00000001 0 0 04 3 00000001 0
alu 4 ffffffff 00000001 0 0 05 4 00000000 0
alu 5 f0f0f0f0 ff00ff00 0 0 06 5 0ff00ff0 0
alu 6 80000000 00000004 0 0 07 6 08000000 0
alu 7 80000000 00000004 0 0 08 7 f8000000 0
alu 8 12340000 00005678 0 0 09 0 12345678 0
alu 9 ffff0000 12345678 0 0 0a 1 12340000 0
mul 0 fffffffe 00000003 0 0 10 2 fffffffa 0
mul 1 fffffffe 00000003 0 0 11 3 ffffffff 0
mul 2 fffffffe ffffffff 0 0 12 4 fffffffe 0
mul 3 ffffffff 00000002 0 0 13 5 00000001 0
mul 1 80000000 80000000 0 0 14 6 40000000 0
mul 0 00012345 00000010 0 0 15 7 00123450 0
bru 0 00000000 00000000 00001000 00000010 0 0 00001010 1
bru 1 00000000 00000000 00002001 00000004 0 0 00002004 1
bru 2 00000005 00000005 00001000 00000020 0 0 00001020 1
bru 2 00000005 00000006 00001000 00000020 0 0 00000000 0
bru 3 00000005 00000006 00001000 fffffff8 0 0 00000ff8 1
bru 4 ffffffff 00000001 00002000 00000008 0 0 00002008 1
bru 5 ffffffff 00000001 00002000 00000008 0 0 00000000 0
bru 6 ffffffff 00000001 00002000 00000008 0 0 00000000 0
bru 7 ffffffff 00000001 00003000 00000004 0 0 00003004 1
bru 0 00000000 00000000 00001000 00000002 0 0 00001002 2
bru 1 00000000 00000000 00001000 00000003 0 0 00001002 2
int 0 00000000 00000000 00001000 00000010 0 0 80000100 1
